// ==== tb.f ====
rs_isa_pkg.sv
rs_uarch_pkg.sv
lsq_tail_tracker.sv
rs.sv
alu_unit.sv
mult_unit.sv
agu_unit.sv
cdb_arbiter.sv
ooo_exec_core.sv
tb_ooo_exec_core.sv

// ==== tb_ooo_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_exec_core
	import rs_isa_pkg::*, rs_uarch_pkg::*;
();

	localparam int max_rows = 64;
	localparam int wait_limit = 300;

	// one instruction of the stimulus table together with what it must produce
	// dep1 and dep2 name an earlier row whose result feeds that source, or -1
	typedef struct {
		alu_func_e func;
		logic rd_mem;
		logic wr_mem;
		logic dest_valid;
		preg_t dest;
		logic s2_used;
		int dep1;
		int dep2;
		word_t v1;
		word_t v2;
		word_t imm;
		int gap;
		logic solo;
		int lat;
		int refuse;
		int blocked_by;
		word_t exp;
		word_t addr;
		sq_idx_t sq_pos;
		lq_idx_t lq_pos;
	} row_t;

	logic clock;
	logic reset;
	is_packet_t is_packet_in;
	logic in_en;
	logic free;
	cdb_t cdb;
	mem_req_t mem_req;

	row_t rows [max_rows];
	logic seen_cdb [max_rows];
	logic seen_mem [max_rows];
	logic dispatched [max_rows];
	int acc_cycle [max_rows];
	int n_rows = 0;
	int n_loads = 0;
	int n_stores = 0;
	int next_preg = 1;
	int cycle = 0;
	int err_count = 0;
	logic [31:0] rng_state = 32'hd56614b4;

	ooo_exec_core u_ooo_exec_core (
		.clock(clock), .reset(reset), .is_packet_in(is_packet_in), .in_en(in_en),
		.free(free), .cdb(cdb), .mem_req(mem_req)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// counts rising edges so that latencies can be measured in cycles
	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic abort_run(input string what);
		err_count++;
		$display("** Error at %0d ns: %s", $time, what);
		stop_run();
	endtask

	task automatic check_equal(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			err_count++;
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, actual,
				expected);
			stop_run();
		end
	endtask

	// expected result of one operation, written from the RV32I and RV32M rules
	function automatic word_t ref_result(alu_func_e f, word_t a, word_t b);
		logic [63:0] wa;
		logic [63:0] wb;
		logic [63:0] wide;
		wa = {32'b0, a};
		wb = {32'b0, b};
		case (f)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or: return a | b;
			alu_xor: return a ^ b;
			alu_sll: return a << b[4:0];
			alu_srl: return a >> b[4:0];
			alu_sra: begin
				wide = {{32{a[31]}}, a} >> b[4:0];
				return wide[31:0];
			end
			// flipping the sign bit turns a signed compare into an unsigned one
			alu_slt: return word_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
			alu_sltu: return word_t'(a < b);
			alu_mul: begin
				wide = wa * wb;
				return wide[31:0];
			end
			alu_mulh: begin
				wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};
				return wide[63:32];
			end
			alu_mulhsu: begin
				wide = {{32{a[31]}}, a} * wb;
				return wide[63:32];
			end
			default: begin
				wide = wa * wb;
				return wide[63:32];
			end
		endcase
	endfunction

	// appends a row with random operands and works out its expected outputs
	task automatic add_row(input alu_func_e f, input logic rd, input logic wr, input int d1,
		input int d2, input logic u2);
		row_t w;
		word_t a;
		word_t b;
		w.func = f;
		w.rd_mem = rd;
		w.wr_mem = wr;
		w.s2_used = u2;
		w.dep1 = d1;
		w.dep2 = u2 ? d2 : -1;
		w.v1 = next_rand();
		w.v2 = next_rand();
		w.imm = next_rand();
		w.gap = 0;
		w.solo = 1'b0;
		w.lat = 0;
		w.refuse = -1;
		w.blocked_by = -1;
		w.dest_valid = !wr;
		w.dest = wr ? preg_t'(0) : preg_t'(next_preg);
		if (!wr) begin
			next_preg++;
		end
		// a dependent source takes the producer's expected result
		a = (w.dep1 >= 0) ? rows[w.dep1].exp : w.v1;
		b = (w.dep2 >= 0) ? rows[w.dep2].exp : w.v2;
		w.addr = a + w.imm;
		if (wr) begin
			w.exp = b;
		end else if (rd) begin
			w.exp = w.addr;
		end else begin
			w.exp = ref_result(f, a, u2 ? b : w.imm);
		end
		// positions follow the tails that count every load and store from reset
		w.lq_pos = lq_idx_t'(n_loads);
		w.sq_pos = sq_idx_t'(n_stores);
		if (rd) begin
			n_loads++;
		end
		if (wr) begin
			n_stores++;
		end
		rows[n_rows] = w;
		n_rows++;
	endtask

	// a producer that has already broadcast is passed in as ready, like rename does
	function automatic src_tag_t make_src(logic used, int dep, word_t v);
		src_tag_t s;
		s.used = used;
		s.ready = 1'b1;
		s.tag = '0;
		s.value = v;
		if (used && dep >= 0) begin
			s.tag = rows[dep].dest;
			s.ready = seen_cdb[dep];
			if (seen_cdb[dep]) begin
				s.value = rows[dep].exp;
			end
		end
		return s;
	endfunction

	function automatic is_packet_t make_packet(int r);
		is_packet_t p;
		p = '0;
		p.func = rows[r].func;
		p.rd_mem = rows[r].rd_mem;
		p.wr_mem = rows[r].wr_mem;
		p.dest_valid = rows[r].dest_valid;
		p.dest = rows[r].dest;
		p.src1 = make_src(1'b1, rows[r].dep1, rows[r].v1);
		p.src2 = make_src(rows[r].s2_used, rows[r].dep2, rows[r].v2);
		p.imm = rows[r].imm;
		return p;
	endfunction

	// a store is finished at its memory request, a load needs its broadcast too
	function automatic logic finished(int r);
		if (rows[r].wr_mem) begin
			return seen_mem[r];
		end
		if (rows[r].rd_mem) begin
			return seen_mem[r] && seen_cdb[r];
		end
		return seen_cdb[r];
	endfunction

	function automatic int first_unfinished();
		for (int i = 0; i < n_rows; i++) begin
			if (!finished(i)) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic int find_cdb_row(preg_t p);
		for (int i = 0; i < n_rows; i++) begin
			if (dispatched[i] && rows[i].dest_valid && !seen_cdb[i] && rows[i].dest == p) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic int find_mem_row(logic store, sq_idx_t sq, lq_idx_t lq);
		for (int i = 0; i < n_rows; i++) begin
			if (dispatched[i] && !seen_mem[i] && (rows[i].rd_mem || rows[i].wr_mem) &&
				rows[i].wr_mem == store &&
				(store ? rows[i].sq_pos == sq : rows[i].lq_pos == lq)) begin
				return i;
			end
		end
		return -1;
	endfunction

	// entered and left 1 ns after a rising edge, free is sampled at the falling edge
	task automatic dispatch_row(input int r);
		int waited;
		waited = 0;
		in_en = 1'b1;
		is_packet_in = make_packet(r);
		@(negedge clock);
		while (!free) begin
			waited++;
			if (waited > wait_limit) begin
				abort_run($sformatf("row %0d was never accepted by the station", r));
			end
			@(posedge clock);
			#1;
			is_packet_in = make_packet(r);
			@(negedge clock);
		end
		// latency counts from the cycle in which in_en and free are both high
		acc_cycle[r] = cycle;
		@(posedge clock);
		#1;
		dispatched[r] = 1'b1;
		in_en = 1'b0;
		if (rows[r].refuse == 0) begin
			check_equal($sformatf("refused cycles of row %0d", r), waited, 0);
		end
		if (rows[r].refuse == 1) begin
			if (waited == 0) begin
				abort_run($sformatf("row %0d was accepted into an occupied slot", r));
			end
			check_equal($sformatf("finished flag of row %0d", rows[r].blocked_by),
				finished(rows[r].blocked_by), 1);
		end
	endtask

	task automatic wait_finished(input int r);
		int n;
		n = 0;
		while (!finished(r)) begin
			n++;
			if (n > wait_limit) begin
				abort_run($sformatf("row %0d never completed", r));
			end
			@(posedge clock);
			#1;
		end
	endtask

	// both buses are registered, so the falling edge sees settled values
	always @(negedge clock) begin
		int r;
		if (!reset) begin
			if (cdb.valid) begin
				r = find_cdb_row(cdb.preg);
				if (r < 0) begin
					abort_run($sformatf("broadcast of preg %0d matches no outstanding row",
						cdb.preg));
				end else begin
					check_equal($sformatf("cdb.value (row %0d)", r), cdb.value, rows[r].exp);
					if (rows[r].lat > 0) begin
						check_equal($sformatf("cdb latency (row %0d)", r), cycle - acc_cycle[r],
							rows[r].lat);
					end
					seen_cdb[r] = 1'b1;
				end
			end
			if (mem_req.valid) begin
				r = find_mem_row(mem_req.store, mem_req.sq_pos, mem_req.lq_pos);
				if (r < 0) begin
					abort_run($sformatf("memory request sq %0d lq %0d matches no row",
						mem_req.sq_pos, mem_req.lq_pos));
				end else begin
					check_equal($sformatf("mem_req.addr (row %0d)", r), mem_req.addr,
						rows[r].addr);
					check_equal($sformatf("mem_req.sq_pos (row %0d)", r), mem_req.sq_pos,
						rows[r].sq_pos);
					check_equal($sformatf("mem_req.lq_pos (row %0d)", r), mem_req.lq_pos,
						rows[r].lq_pos);
					if (rows[r].wr_mem) begin
						check_equal($sformatf("mem_req.data (row %0d)", r), mem_req.data,
							rows[r].exp);
					end
					seen_mem[r] = 1'b1;
				end
			end
		end
	end

	initial begin
		int ia;
		int ib;
		int ic;
		int idx;
		int n;
		reset = 1'b1;
		in_en = 1'b0;
		is_packet_in = '0;
		for (int i = 0; i < max_rows; i++) begin
			seen_cdb[i] = 1'b0;
			seen_mem[i] = 1'b0;
			dispatched[i] = 1'b0;
			acc_cycle[i] = 0;
		end

		// independent ALU functions, each one alone with a fixed latency
		for (int i = 0; i < 10; i++) begin
			add_row(alu_func_e'(i), 1'b0, 1'b0, -1, -1, i % 3 != 0);
			rows[n_rows-1].solo = 1'b1;
			rows[n_rows-1].lat = 3;
		end
		// every multiply variant alone, then two that fill slots 3 and 4 together
		for (int i = 10; i < 14; i++) begin
			add_row(alu_func_e'(i), 1'b0, 1'b0, -1, -1, 1'b1);
			rows[n_rows-1].solo = 1'b1;
			rows[n_rows-1].lat = 5;
		end
		add_row(alu_mulh, 1'b0, 1'b0, -1, -1, 1'b1);
		rows[n_rows-1].lat = 5;
		add_row(alu_mulhu, 1'b0, 1'b0, -1, -1, 1'b1);
		rows[n_rows-1].lat = 5;
		rows[n_rows-1].refuse = 0;
		rows[n_rows-1].solo = 1'b1;

		// dependent chain through the ALU, the multiplier and the address unit
		ia = n_rows;
		add_row(alu_add, 1'b0, 1'b0, -1, -1, 1'b1);
		ib = n_rows;
		add_row(alu_mul, 1'b0, 1'b0, ia, -1, 1'b1);
		ic = n_rows;
		add_row(alu_add, 1'b1, 1'b0, ib, -1, 1'b0);
		add_row(alu_add, 1'b0, 1'b1, ia, ic, 1'b1);
		add_row(alu_xor, 1'b0, 1'b0, ic, ib, 1'b1);
		rows[n_rows-1].solo = 1'b1;
		// the load arrives in the very cycle its producer is on the bus
		ia = n_rows;
		add_row(alu_sub, 1'b0, 1'b0, -1, -1, 1'b1);
		rows[ia].gap = 4;
		rows[ia].lat = 3;
		add_row(alu_add, 1'b1, 1'b0, ia, -1, 1'b0);
		rows[n_rows-1].gap = 2;
		rows[n_rows-1].refuse = 0;
		rows[n_rows-1].lat = 3;
		rows[n_rows-1].solo = 1'b1;

		// loads and stores, enough of them to wrap the load queue tail
		for (int i = 0; i < 6; i++) begin
			add_row(alu_add, 1'b1, 1'b0, -1, -1, 1'b0);
			add_row(alu_add, 1'b0, 1'b1, -1, -1, 1'b1);
		end
		rows[n_rows-1].solo = 1'b1;

		// a third multiply waits for the first of the two in flight
		ia = n_rows;
		add_row(alu_mul, 1'b0, 1'b0, -1, -1, 1'b1);
		add_row(alu_mulhsu, 1'b0, 1'b0, -1, -1, 1'b1);
		rows[n_rows-1].refuse = 0;
		add_row(alu_mulhu, 1'b0, 1'b0, -1, -1, 1'b1);
		rows[n_rows-1].refuse = 1;
		rows[n_rows-1].blocked_by = ia;
		// an ALU slot held by a waiting instruction refuses the next one
		ia = n_rows;
		add_row(alu_mul, 1'b0, 1'b0, -1, -1, 1'b1);
		ib = n_rows;
		add_row(alu_add, 1'b0, 1'b0, ia, -1, 1'b0);
		add_row(alu_or, 1'b0, 1'b0, -1, -1, 1'b1);
		rows[n_rows-1].refuse = 1;
		rows[n_rows-1].blocked_by = ib;
		ia = n_rows;
		add_row(alu_add, 1'b1, 1'b0, -1, -1, 1'b0);
		add_row(alu_add, 1'b1, 1'b0, -1, -1, 1'b0);
		rows[n_rows-1].refuse = 1;
		rows[n_rows-1].blocked_by = ia;
		rows[n_rows-1].solo = 1'b1;

		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		check_equal("free", free, 1);
		check_equal("cdb.valid", cdb.valid, 0);
		check_equal("mem_req.valid", mem_req.valid, 0);
		@(posedge clock);
		#1;

		for (int r = 0; r < n_rows; r++) begin
			if (rows[r].gap > 0) begin
				repeat (rows[r].gap) @(posedge clock);
				#1;
			end
			dispatch_row(r);
			if (rows[r].solo) begin
				wait_finished(r);
			end
		end

		n = 0;
		idx = first_unfinished();
		while (idx >= 0) begin
			n++;
			if (n > wait_limit) begin
				abort_run($sformatf("row %0d never completed", idx));
			end
			@(posedge clock);
			#1;
			idx = first_unfinished();
		end
		// a few idle cycles expose any second broadcast of a finished row
		repeat (10) @(posedge clock);
		#1;

		if (err_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

`default_nettype wire

// ==== ooo_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_exec_core
	import rs_uarch_pkg::*;
(
	input logic clock,
	input logic reset,
	input is_packet_t is_packet_in,
	input logic in_en,
	output logic free,
	output cdb_t cdb,
	output mem_req_t mem_req
);

	sq_idx_t sq_tail;
	lq_idx_t lq_tail;
	logic alloc_load;
	logic alloc_store;
	fu_req_t alu_req;
	fu_req_t mul_req;
	fu_req_t agu_req;
	logic alu_ready;
	logic mul_ready;
	logic agu_ready;
	fu_done_t alu_done;
	fu_done_t mul_done;
	fu_done_t agu_done;
	logic alu_grant;
	logic mul_grant;
	logic agu_grant;
	logic rel_en;
	rs_idx_t rel_idx;

	lsq_tail_tracker u_lsq_tail_tracker (
		.clock(clock), .reset(reset), .alloc_load(alloc_load), .alloc_store(alloc_store),
		.sq_tail(sq_tail), .lq_tail(lq_tail)
	);

	// the bus result feeds back into the station for wakeup
	rs u_rs (
		.clock(clock), .reset(reset), .is_packet_in(is_packet_in), .in_en(in_en),
		.free(free), .cdb(cdb), .sq_tail(sq_tail), .lq_tail(lq_tail),
		.alu_ready(alu_ready), .mul_ready(mul_ready), .agu_ready(agu_ready),
		.alu_req(alu_req), .mul_req(mul_req), .agu_req(agu_req),
		.rel_en(rel_en), .rel_idx(rel_idx),
		.alloc_load(alloc_load), .alloc_store(alloc_store)
	);

	alu_unit u_alu_unit (
		.clock(clock), .reset(reset), .req(alu_req), .ready(alu_ready),
		.done(alu_done), .grant(alu_grant)
	);

	mult_unit u_mult_unit (
		.clock(clock), .reset(reset), .req(mul_req), .ready(mul_ready),
		.done(mul_done), .grant(mul_grant)
	);

	agu_unit u_agu_unit (
		.clock(clock), .reset(reset), .req(agu_req), .ready(agu_ready),
		.done(agu_done), .grant(agu_grant), .mem_req(mem_req)
	);

	cdb_arbiter u_cdb_arbiter (
		.clock(clock), .reset(reset),
		.alu_done(alu_done), .mul_done(mul_done), .agu_done(agu_done),
		.alu_grant(alu_grant), .mul_grant(mul_grant), .agu_grant(agu_grant),
		.cdb(cdb), .rel_en(rel_en), .rel_idx(rel_idx)
	);

endmodule

`default_nettype wire

// ==== cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter
	import rs_uarch_pkg::*;
(
	input logic clock,
	input logic reset,
	input fu_done_t alu_done,
	input fu_done_t mul_done,
	input fu_done_t agu_done,
	output logic alu_grant,
	output logic mul_grant,
	output logic agu_grant,
	output cdb_t cdb,
	output logic rel_en,
	output rs_idx_t rel_idx
);

	fu_done_t win;

	// the multiplier goes first since a stall there blocks three results
	always_comb begin
		mul_grant = mul_done.valid;
		agu_grant = agu_done.valid && !mul_done.valid;
		alu_grant = alu_done.valid && !mul_done.valid && !agu_done.valid;
		win = alu_done;
		if (agu_grant) begin
			win = agu_done;
		end
		if (mul_grant) begin
			win = mul_done;
		end
	end

	// a store releases its slot without a broadcast
	always_ff @(posedge clock) begin
		cdb.valid <= win.valid && win.dest_valid;
		cdb.preg <= win.dest;
		cdb.value <= win.result;
		rel_en <= win.valid;
		rel_idx <= win.idx;
		if (reset) begin
			cdb.valid <= 1'b0;
			rel_en <= 1'b0;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		$onehot0({alu_grant, mul_grant, agu_grant}))
		else $error("more than one unit granted");

endmodule

`default_nettype wire

// ==== agu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module agu_unit
	import rs_isa_pkg::*, rs_uarch_pkg::*;
(
	input logic clock,
	input logic reset,
	input fu_req_t req,
	output logic ready,
	output fu_done_t done,
	input logic grant,
	output mem_req_t mem_req
);

	word_t addr;

	assign addr = req.pkt.src1.value + req.pkt.imm;
	assign ready = !done.valid || grant;

	always_ff @(posedge clock) begin
		// the memory request is a single-cycle pulse, memory never pushes back
		mem_req <= '{valid: req.valid, store: req.pkt.wr_mem, addr: addr,
			data: req.pkt.src2.value, sq_pos: req.sq_pos, lq_pos: req.lq_pos};
		// stores still report done so their slot gets released
		// their dest_valid is low and keeps them off the bus
		if (req.valid) begin
			done <= '{valid: 1'b1, idx: req.idx, dest_valid: req.pkt.dest_valid,
				dest: req.pkt.dest, result: addr};
		end else if (grant) begin
			done.valid <= 1'b0;
		end
		if (reset) begin
			mem_req.valid <= 1'b0;
			done.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== mult_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_unit
	import rs_isa_pkg::*, rs_uarch_pkg::*;
(
	input logic clock,
	input logic reset,
	input fu_req_t req,
	output logic ready,
	output fu_done_t done,
	input logic grant
);

	// bookkeeping that travels alongside the operands through the pipe
	typedef struct packed {
		logic valid;
		rs_idx_t idx;
		logic dest_valid;
		preg_t dest;
		alu_func_e func;
	} mul_meta_t;

	mul_meta_t s1_meta;
	mul_meta_t s2_meta;
	logic signed [xlen:0] s1_a;
	logic signed [xlen:0] s1_b;
	logic [2*xlen-1:0] s2_prod;
	word_t op_a;
	word_t op_b;
	logic a_signed;
	logic b_signed;
	logic stall;

	assign op_a = req.pkt.src1.value;
	assign op_b = req.pkt.src2.used ? req.pkt.src2.value : req.pkt.imm;

	// MULH treats both operands as signed, MULHSU only the first
	// for MUL the low half is the same either way
	assign a_signed = req.pkt.func inside {alu_mulh, alu_mulhsu};
	assign b_signed = req.pkt.func == alu_mulh;

	// an ungranted result in stage 3 freezes every stage behind it
	assign stall = done.valid && !grant;
	assign ready = !stall;

	always_ff @(posedge clock) begin
		if (!stall) begin
			s1_meta <= '{valid: req.valid, idx: req.idx, dest_valid: req.pkt.dest_valid,
				dest: req.pkt.dest, func: req.pkt.func};
			s1_a <= {a_signed & op_a[xlen-1], op_a};
			s1_b <= {b_signed & op_b[xlen-1], op_b};
			s2_meta <= s1_meta;
			// 33 by 33 bit signed product, the low 64 bits are exact
			s2_prod <= s1_a * s1_b;
			done.valid <= s2_meta.valid;
			done.idx <= s2_meta.idx;
			done.dest_valid <= s2_meta.dest_valid;
			done.dest <= s2_meta.dest;
			done.result <= (s2_meta.func == alu_mul) ? s2_prod[xlen-1:0] :
				s2_prod[2*xlen-1:xlen];
		end
		if (reset) begin
			s1_meta.valid <= 1'b0;
			s2_meta.valid <= 1'b0;
			done.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit
	import rs_isa_pkg::*, rs_uarch_pkg::*;
(
	input logic clock,
	input logic reset,
	input fu_req_t req,
	output logic ready,
	output fu_done_t done,
	input logic grant
);

	word_t a;
	word_t b;
	shamt_t shamt;
	word_t res;

	// the immediate stands in for the second source on I-type forms
	assign a = req.pkt.src1.value;
	assign b = req.pkt.src2.used ? req.pkt.src2.value : req.pkt.imm;
	assign shamt = b[shamt_w-1:0];

	always_comb begin
		case (req.pkt.func)
			alu_add: res = a + b;
			alu_sub: res = a - b;
			alu_and: res = a & b;
			alu_or: res = a | b;
			alu_xor: res = a ^ b;
			alu_sll: res = a << shamt;
			alu_srl: res = a >> shamt;
			alu_sra: res = word_t'($signed(a) >>> shamt);
			alu_slt: res = word_t'($signed(a) < $signed(b));
			alu_sltu: res = word_t'(a < b);
			default: res = '0;
		endcase
	end

	// a result being granted this cycle frees the register for a new one
	assign ready = !done.valid || grant;

	always_ff @(posedge clock) begin
		if (req.valid) begin
			done <= '{valid: 1'b1, idx: req.idx, dest_valid: req.pkt.dest_valid,
				dest: req.pkt.dest, result: res};
		end else if (grant) begin
			done.valid <= 1'b0;
		end
		if (reset) begin
			done.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs
	import rs_uarch_pkg::*;
(
	input logic clock,
	input logic reset,
	input is_packet_t is_packet_in,
	input logic in_en,
	output logic free,
	input cdb_t cdb,
	input sq_idx_t sq_tail,
	input lq_idx_t lq_tail,
	input logic alu_ready,
	input logic mul_ready,
	input logic agu_ready,
	output fu_req_t alu_req,
	output fu_req_t mul_req,
	output fu_req_t agu_req,
	input logic rel_en,
	input rs_idx_t rel_idx,
	output logic alloc_load,
	output logic alloc_store
);

	// issued keeps a slot from being picked again while its unit works on it
	typedef struct packed {
		logic busy;
		logic issued;
		sq_idx_t sq_pos;
		lq_idx_t lq_pos;
		is_packet_t pkt;
	} rs_entry_t;

	rs_entry_t tbl [rs_sz];
	rs_idx_t alloc_idx;
	logic accept;
	is_packet_t new_pkt;
	logic [rs_sz-1:0] unit_rdy;
	logic [rs_sz-1:0] cand;
	logic sel_found;
	rs_idx_t sel_idx;

	// a source picks up the broadcast value when its tag is on the bus
	function automatic src_tag_t wake(src_tag_t s, cdb_t c);
		src_tag_t r;
		r = s;
		if (c.valid && s.used && !s.ready && s.tag == c.preg) begin
			r.ready = 1'b1;
			r.value = c.value;
		end
		return r;
	endfunction

	// stores and loads have one slot each, multiplies spill into slot 4
	always_comb begin
		if (is_packet_in.wr_mem) begin
			alloc_idx = slot_store;
		end else if (is_packet_in.rd_mem) begin
			alloc_idx = slot_load;
		end else if (!is_mul_func(is_packet_in.func)) begin
			alloc_idx = slot_alu;
		end else if (tbl[slot_mul0].busy) begin
			alloc_idx = slot_mul1;
		end else begin
			alloc_idx = slot_mul0;
		end
	end

	assign free = !tbl[alloc_idx].busy;
	assign accept = in_en && free;
	assign alloc_load = accept && is_packet_in.rd_mem;
	assign alloc_store = accept && is_packet_in.wr_mem;

	// a tag broadcast in the dispatch cycle would otherwise be missed
	always_comb begin
		new_pkt = is_packet_in;
		new_pkt.src1 = wake(is_packet_in.src1, cdb);
		new_pkt.src2 = wake(is_packet_in.src2, cdb);
	end

	// map each slot to the ready signal of the unit it feeds
	always_comb begin
		unit_rdy[slot_alu] = alu_ready;
		unit_rdy[slot_load] = agu_ready;
		unit_rdy[slot_store] = agu_ready;
		unit_rdy[slot_mul0] = mul_ready;
		unit_rdy[slot_mul1] = mul_ready;
	end

	// scanning downwards leaves the lowest-numbered candidate selected
	always_comb begin
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = rs_sz - 1; i >= 0; i--) begin
			cand[i] = tbl[i].busy && !tbl[i].issued && unit_rdy[i] &&
				(!tbl[i].pkt.src1.used || tbl[i].pkt.src1.ready) &&
				(!tbl[i].pkt.src2.used || tbl[i].pkt.src2.ready);
			if (cand[i]) begin
				sel_found = 1'b1;
				sel_idx = rs_idx_t'(i);
			end
		end
	end

	// all three requests carry the same payload, only one valid can be high
	always_comb begin
		alu_req.pkt = tbl[sel_idx].pkt;
		alu_req.idx = sel_idx;
		alu_req.sq_pos = tbl[sel_idx].sq_pos;
		alu_req.lq_pos = tbl[sel_idx].lq_pos;
		alu_req.valid = 1'b0;
		mul_req = alu_req;
		agu_req = alu_req;
		alu_req.valid = sel_found && sel_idx == slot_alu;
		agu_req.valid = sel_found && (sel_idx == slot_load || sel_idx == slot_store);
		mul_req.valid = sel_found && (sel_idx == slot_mul0 || sel_idx == slot_mul1);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rs_sz; i++) begin
				tbl[i].busy <= 1'b0;
				tbl[i].issued <= 1'b0;
			end
		end else begin
			// wakeup only touches occupied slots
			for (int i = 0; i < rs_sz; i++) begin
				if (tbl[i].busy) begin
					tbl[i].pkt.src1 <= wake(tbl[i].pkt.src1, cdb);
					tbl[i].pkt.src2 <= wake(tbl[i].pkt.src2, cdb);
				end
			end
			if (rel_en) begin
				tbl[rel_idx].busy <= 1'b0;
				tbl[rel_idx].issued <= 1'b0;
			end
			if (sel_found) begin
				tbl[sel_idx].issued <= 1'b1;
			end
			// both tails are recorded before the tracker advances them
			if (accept) begin
				tbl[alloc_idx] <= '{busy: 1'b1, issued: 1'b0, sq_pos: sq_tail,
					lq_pos: lq_tail, pkt: new_pkt};
			end
		end
	end

	// the accepted slot was empty and holds the instruction one cycle later
	assert property (@(posedge clock) disable iff (reset)
		accept |-> !tbl[alloc_idx].busy ##1 tbl[$past(alloc_idx)].busy)
		else $error("dispatch into an occupied slot");

	// the arbiter may only release a slot whose instruction was issued
	assert property (@(posedge clock) disable iff (reset)
		rel_en |-> tbl[rel_idx].busy && tbl[rel_idx].issued)
		else $error("release of a slot that was never issued");

endmodule

`default_nettype wire

// ==== lsq_tail_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_tail_tracker
	import rs_uarch_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic alloc_load,
	input logic alloc_store,
	output sq_idx_t sq_tail,
	output lq_idx_t lq_tail
);

	// both tails are plain counters that wrap at the queue depth
	// the station reads the current values before they move
	always_ff @(posedge clock) begin
		if (reset) begin
			sq_tail <= '0;
			lq_tail <= '0;
		end else begin
			if (alloc_load) begin
				lq_tail <= lq_tail + lq_idx_t'(1);
			end
			if (alloc_store) begin
				sq_tail <= sq_tail + sq_idx_t'(1);
			end
		end
	end

	// one instruction per cycle is either a load or a store, never both
	assert property (@(posedge clock) disable iff (reset) !(alloc_load && alloc_store))
		else $error("load and store allocated in the same cycle");

endmodule

`default_nettype wire

// ==== rs_uarch_pkg.sv ====
`default_nettype none

package rs_uarch_pkg;
	import rs_isa_pkg::*;

	// station geometry and the queue and register file sizes it refers to
	localparam int rs_sz = 5;
	localparam int sq_sz = 8;
	localparam int lq_sz = 8;
	localparam int prf_sz = 64;

	typedef logic [$clog2(rs_sz)-1:0] rs_idx_t;
	typedef logic [$clog2(sq_sz)-1:0] sq_idx_t;
	typedef logic [$clog2(lq_sz)-1:0] lq_idx_t;
	typedef logic [$clog2(prf_sz)-1:0] preg_t;

	// every instruction class owns a fixed slot, multiplies own two
	localparam rs_idx_t slot_alu = 3'd0;
	localparam rs_idx_t slot_load = 3'd1;
	localparam rs_idx_t slot_store = 3'd2;
	localparam rs_idx_t slot_mul0 = 3'd3;
	localparam rs_idx_t slot_mul1 = 3'd4;

	// one source operand, value is only meaningful once ready is set
	typedef struct packed {
		logic used;
		logic ready;
		preg_t tag;
		word_t value;
	} src_tag_t;

	// renamed instruction as it arrives from dispatch
	typedef struct packed {
		alu_func_e func;
		logic rd_mem;
		logic wr_mem;
		logic dest_valid;
		preg_t dest;
		src_tag_t src1;
		src_tag_t src2;
		word_t imm;
	} is_packet_t;

	// issue request from the station to one execute unit
	typedef struct packed {
		logic valid;
		is_packet_t pkt;
		rs_idx_t idx;
		sq_idx_t sq_pos;
		lq_idx_t lq_pos;
	} fu_req_t;

	// finished result waiting for the completion arbiter
	typedef struct packed {
		logic valid;
		rs_idx_t idx;
		logic dest_valid;
		preg_t dest;
		word_t result;
	} fu_done_t;

	typedef struct packed {
		logic valid;
		preg_t preg;
		word_t value;
	} cdb_t;

	typedef struct packed {
		logic valid;
		logic store;
		word_t addr;
		word_t data;
		sq_idx_t sq_pos;
		lq_idx_t lq_pos;
	} mem_req_t;

	// true for the functions that belong to the multiplier slots
	function automatic logic is_mul_func(alu_func_e f);
		return f inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu};
	endfunction

endpackage

`default_nettype wire

// ==== rs_isa_pkg.sv ====
`default_nettype none

package rs_isa_pkg;

	// integer datapath width of the RV32 core
	localparam int xlen = 32;

	// register shifts only look at the low bits of the second operand
	localparam int shamt_w = 5;

	// enough bits to encode every ALU and multiply function below
	localparam int func_w = 4;

	typedef logic [xlen-1:0] word_t;
	typedef logic [shamt_w-1:0] shamt_t;

	// functions that the execute units understand
	// the last four are routed to the multiplier, everything else to the ALU
	typedef enum logic [func_w-1:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_mul,
		alu_mulh,
		alu_mulhsu,
		alu_mulhu
	} alu_func_e;

endpackage

`default_nettype wire
